// File: design/spi_cmd_decode.sv
`include "spi_macros.svh"

module spi_cmd_decode (
	input  logic clk,
	input  logic arst_n,
	input  logic wr_valid,
	input  spi_pkg::spi_wr_t wr,
	output logic wr_ready,
	output logic cmd_valid,
	output spi_pkg::spi_cmd_t cmd,
	input  logic cmd_ready
);
	import spi_pkg::*;

	spi_cfg_t cfg;
	spi_cfg_t cfg_next;
	spi_cmd_t cmd_in;
	logic wr_fire;
	logic is_cfg;
	logic push;
	logic q_ready;

	// Writes stall only while the command FIFO is full
	assign wr_ready = q_ready;
	assign wr_fire = wr_valid && wr_ready;
	assign is_cfg = (wr.addr == `SPI_ADDR_CFG);

	// DATA writes with the block disabled are accepted and dropped
	assign push = wr_valid && (wr.addr == `SPI_ADDR_DATA) && cfg.enable;

	// CFG register layout
	always_comb begin
		cfg_next = '0;
		cfg_next.enable = wr.data[0];
		cfg_next.cpol = wr.data[2];
		cfg_next.cpha = wr.data[3];
		cfg_next.lsb_first = wr.data[4];
		cfg_next.select = wr.data[6:5];
		cfg_next.prescale = wr.data[15:8];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg <= '0;
		end else if (wr_fire && is_cfg) begin
			cfg <= cfg_next;
		end
	end

	// Snapshot of the current config travels with each byte
	assign cmd_in.prescale = cfg.prescale;
	assign cmd_in.select = cfg.select;
	assign cmd_in.cpol = cfg.cpol;
	assign cmd_in.cpha = cfg.cpha;
	assign cmd_in.lsb_first = cfg.lsb_first;
	assign cmd_in.tx_data = wr.data[`SPI_DATA_W-1:0];

	spi_queue #(.T(spi_cmd_t)) u_cmd_q (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(push),
		.in_data(cmd_in),
		.in_ready(q_ready),
		.out_valid(cmd_valid),
		.out_data(cmd),
		.out_ready(cmd_ready),
		.full()
	);

endmodule

// File: design/spi_master_top.sv
`include "spi_macros.svh"

module spi_master_top (
	input  logic clk,
	input  logic arst_n,
	input  logic wr_valid,
	output logic wr_ready,
	input  spi_pkg::spi_wr_t wr,
	output logic rsp_valid,
	input  logic rsp_ready,
	output spi_pkg::spi_rsp_t rsp,
	output logic sck,
	output logic mosi,
	input  logic miso,
	output logic [`SPI_SLAVES-1:0] ss_n
);
	import spi_pkg::*;

	spi_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	logic space;
	logic done;
	logic [`SPI_DATA_W-1:0] rx_byte;
	logic [`SPI_SEL_W-1:0] rx_select;

	// Host writes become queued commands
	spi_cmd_decode u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.wr_valid(wr_valid),
		.wr(wr),
		.wr_ready(wr_ready),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_ready(cmd_ready)
	);

	spi_shift_engine u_engine (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_ready(cmd_ready),
		.space(space),
		.sck(sck),
		.mosi(mosi),
		.miso(miso),
		.ss_n(ss_n),
		.done(done),
		.rx_byte(rx_byte),
		.rx_select(rx_select)
	);

	// Tagged results back to the host
	spi_rsp_collect u_collect (
		.clk(clk),
		.arst_n(arst_n),
		.done(done),
		.rx_byte(rx_byte),
		.rx_select(rx_select),
		.space(space),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.rsp_ready(rsp_ready)
	);

endmodule

// File: design/spi_pkg.sv
`include "spi_macros.svh"

package spi_pkg;

	// Live configuration held by the decoder
	typedef struct packed {
		logic [7:0] prescale;
		logic [`SPI_SEL_W-1:0] select;
		logic cpol;
		logic cpha;
		logic lsb_first;
		logic enable;
	} spi_cfg_t;

	// One queued transfer, a snapshot of the config plus its byte
	typedef struct packed {
		logic [7:0] prescale;
		logic [`SPI_SEL_W-1:0] select;
		logic cpol;
		logic cpha;
		logic lsb_first;
		logic [`SPI_DATA_W-1:0] tx_data;
	} spi_cmd_t;

	// Received byte tagged for the host
	typedef struct packed {
		logic [`SPI_DATA_W-1:0] rx_data;
		logic [`SPI_SEL_W-1:0] select;
		// Completed transfers, wraps at 16
		logic [3:0] seq;
	} spi_rsp_t;

	// Host register write
	typedef struct packed {
		logic addr;
		logic [31:0] data;
	} spi_wr_t;

endpackage

// File: design/spi_queue.sv
`include "spi_macros.svh"

module spi_queue #(
	parameter type T = logic [`SPI_DATA_W-1:0]
) (
	input  logic clk,
	input  logic arst_n,
	input  logic in_valid,
	input  T     in_data,
	output logic in_ready,
	output logic out_valid,
	output T     out_data,
	input  logic out_ready,
	output logic full
);
	localparam int DEPTH = `SPI_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign full = (count == CNT_W'(DEPTH));
	assign in_ready = !full;
	assign out_valid = (count != '0);
	// Head entry shows directly on the output
	assign out_data = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	// Payload storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: design/spi_rsp_collect.sv
`include "spi_macros.svh"

module spi_rsp_collect (
	input  logic clk,
	input  logic arst_n,
	input  logic done,
	input  logic [`SPI_DATA_W-1:0] rx_byte,
	input  logic [`SPI_SEL_W-1:0] rx_select,
	output logic space,
	output logic rsp_valid,
	output spi_pkg::spi_rsp_t rsp,
	input  logic rsp_ready
);
	import spi_pkg::*;

	spi_rsp_t rsp_in;
	logic [3:0] seq;
	logic q_full;

	// Count of finished transfers, first response carries 0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seq <= '0;
		end else if (done) begin
			seq <= seq + 1'b1;
		end
	end

	assign rsp_in.rx_data = rx_byte;
	assign rsp_in.select = rx_select;
	assign rsp_in.seq = seq;

	// Engine waits for a free slot before each transfer
	assign space = !q_full;

	spi_queue #(.T(spi_rsp_t)) u_rsp_q (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(done),
		.in_data(rsp_in),
		.in_ready(),
		.out_valid(rsp_valid),
		.out_data(rsp),
		.out_ready(rsp_ready),
		.full(q_full)
	);

endmodule

// File: design/spi_shift_engine.sv
`include "spi_macros.svh"

module spi_shift_engine (
	input  logic clk,
	input  logic arst_n,
	input  logic cmd_valid,
	input  spi_pkg::spi_cmd_t cmd,
	output logic cmd_ready,
	input  logic space,
	output logic sck,
	output logic mosi,
	input  logic miso,
	output logic [`SPI_SLAVES-1:0] ss_n,
	output logic done,
	output logic [`SPI_DATA_W-1:0] rx_byte,
	output logic [`SPI_SEL_W-1:0] rx_select
);
	import spi_pkg::*;

	localparam int W = `SPI_DATA_W;
	localparam int EDGES = 2 * W;
	localparam int EDGE_W = $clog2(EDGES + 1);
	localparam logic [`SPI_SLAVES-1:0] SEL_ONE = 1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_FINISH
	} state_t;

	state_t state;
	spi_cmd_t cur;
	logic [7:0] div_cnt;
	logic [EDGE_W-1:0] edge_cnt;
	logic [W-1:0] tx_sr;
	logic [W-1:0] rx_sr;
	logic start;
	logic tick;
	logic odd_edge;
	logic launch;
	logic sample;
	logic tx_bit;

	// Drop the bit just sent, direction set by order
	function automatic logic [W-1:0] shift_out(input logic [W-1:0] v, input logic lsb);
		return lsb ? (v >> 1) : (v << 1);
	endfunction

	// No start while a done is still landing in the response FIFO
	assign cmd_ready = (state == ST_IDLE) && space && !done;
	assign start = cmd_valid && cmd_ready;

	// Half period ends after prescale+1 clocks
	assign tick = (state != ST_IDLE) && (div_cnt == cur.prescale);

	// Edge about to be made is odd while the count is even
	assign odd_edge = !edge_cnt[0];

	// cpha 0 launches at start and on even edges, last edge excluded
	// cpha 1 launches on odd edges
	assign launch = tick && (state == ST_SHIFT) &&
		(cur.cpha ? odd_edge : (!odd_edge && edge_cnt != EDGE_W'(EDGES - 1)));
	assign sample = tick && (state == ST_SHIFT) && (cur.cpha ? !odd_edge : odd_edge);

	assign tx_bit = cur.lsb_first ? tx_sr[0] : tx_sr[W-1];
	assign rx_byte = rx_sr;
	assign rx_select = cur.select;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			div_cnt <= '0;
			edge_cnt <= '0;
			sck <= 1'b0;
			mosi <= 1'b1;
			ss_n <= '1;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_SHIFT;
						div_cnt <= '0;
						edge_cnt <= '0;
						sck <= cmd.cpol;
						ss_n <= ~(SEL_ONE << cmd.select);
						// cpha 0 shows the first bit before any edge
						if (!cmd.cpha) begin
							mosi <= cmd.lsb_first ? cmd.tx_data[0] : cmd.tx_data[W-1];
						end
					end else if (cmd_valid) begin
						// Settle to the polarity of the waiting command
						sck <= cmd.cpol;
					end
				end
				ST_SHIFT, ST_FINISH: begin
					div_cnt <= tick ? '0 : div_cnt + 1'b1;
					if (tick && state == ST_FINISH) begin
						state <= ST_IDLE;
						ss_n <= '1;
						mosi <= 1'b1;
						done <= 1'b1;
					end else if (tick) begin
						sck <= ~sck;
						edge_cnt <= edge_cnt + 1'b1;
						if (edge_cnt == EDGE_W'(EDGES - 1)) begin
							state <= ST_FINISH;
						end
						if (launch) begin
							mosi <= tx_bit;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Transfer payload and shift registers
	always_ff @(posedge clk) begin
		if (start) begin
			cur <= cmd;
			// First bit already on mosi for cpha 0
			tx_sr <= cmd.cpha ? cmd.tx_data : shift_out(cmd.tx_data, cmd.lsb_first);
		end else if (launch) begin
			tx_sr <= shift_out(tx_sr, cur.lsb_first);
		end
		if (sample) begin
			rx_sr <= cur.lsb_first ? {miso, rx_sr[W-1:1]} : {rx_sr[W-2:0], miso};
		end
	end

endmodule

// File: include/spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Bits per SPI transfer
`define SPI_DATA_W 8

// Slave selects and the width of a select index
`define SPI_SLAVES 4
`define SPI_SEL_W 2

// Register map on the 1-bit write address
`define SPI_ADDR_CFG 1'b0
`define SPI_ADDR_DATA 1'b1

// Entries in each command and response FIFO
`define SPI_QUEUE_DEPTH 2

`endif

// File: verif/spi_props.sv
`include "spi_macros.svh"

module spi_props (
	input logic clk,
	input logic arst_n,
	input logic wr_valid,
	input logic wr_ready,
	input spi_pkg::spi_wr_t wr,
	input logic rsp_valid,
	input logic rsp_ready,
	input spi_pkg::spi_rsp_t rsp,
	input logic sck,
	input logic [`SPI_SLAVES-1:0] ss_n,
	input logic cur_cpol
);
	int fail_cnt = 0;

	// One slave at a time
	a_one_select: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(~ss_n))
		else begin
			$error("more than one slave select low");
			fail_cnt++;
		end

	a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else begin
			$error("response changed while stalled");
			fail_cnt++;
		end

	a_wr_hold: assert property (@(posedge clk) disable iff (!arst_n)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr))
		else begin
			$error("write dropped before acceptance");
			fail_cnt++;
		end

	// sck is back at its rest level when the select closes
	a_sck_rest: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(&ss_n) |-> sck == cur_cpol)
		else begin
			$error("sck not at rest level when select closed");
			fail_cnt++;
		end

endmodule

bind spi_master_top spi_props u_props (.*, .cur_cpol(u_engine.cur.cpol));

// File: verif/spi_tb.sv
`include "spi_macros.svh"

module spi_tb;
	import spi_pkg::*;

	localparam int LIMIT = 20000;

	logic clk;
	logic arst_n;
	logic wr_valid;
	logic wr_ready;
	spi_wr_t wr;
	logic rsp_valid;
	logic rsp_ready;
	spi_rsp_t rsp;
	logic sck;
	logic mosi;
	logic miso;
	logic [`SPI_SLAVES-1:0] ss_n;
	logic [`SPI_DATA_W-1:0] slave_rx;

	// Reference model state
	spi_cfg_t cfg_model;
	spi_cmd_t xfer_q[$];
	spi_rsp_t exp_q[$];
	spi_cmd_t cur_xfer;
	logic [3:0] model_seq;
	logic active;
	logic prev_sck;
	int gap;
	int edges;
	int started;
	string test_name;

	spi_master_top u_dut (
		.clk(clk), .arst_n(arst_n),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr(wr),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
		.sck(sck), .mosi(mosi), .miso(miso), .ss_n(ss_n)
	);

	spi_tb_slave u_slave (
		.clk(clk), .sck(sck), .mosi(mosi), .ss_n(ss_n),
		.miso(miso), .rx_byte(slave_rx)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic compare_rsp(input spi_rsp_t exp, input spi_rsp_t act);
		if (act !== exp) begin
			stop_with_failure($sformatf("error %s rsp expected %h actual %h",
				test_name, exp, act));
		end
	endtask

	task automatic compare_byte(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			stop_with_failure($sformatf("error %s mosi expected %h actual %h",
				test_name, exp, act));
		end
	endtask

	task automatic compare_ss(input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			stop_with_failure($sformatf("error %s ss_n expected %b actual %b",
				test_name, exp, act));
		end
	endtask

	task automatic compare_count(input int exp, input int act);
		if (act != exp) begin
			stop_with_failure($sformatf("error %s count expected %0d actual %0d",
				test_name, exp, act));
		end
	endtask

	task automatic compare_bit(input logic exp, input logic act);
		if (act !== exp) begin
			stop_with_failure($sformatf("error %s bit expected %b actual %b",
				test_name, exp, act));
		end
	endtask

	// Only the chosen slave has its select bit low
	function automatic logic [`SPI_SLAVES-1:0] select_pattern(
			input logic [`SPI_SEL_W-1:0] sel);
		logic [`SPI_SLAVES-1:0] pat;
		for (int i = 0; i < `SPI_SLAVES; i++) begin
			pat[i] = (i != sel);
		end
		return pat;
	endfunction

	// One register write with the model updated on acceptance
	task automatic write_reg(input logic addr, input logic [31:0] data);
		int n;
		spi_cmd_t cmd;
		logic [7:0] sb;
		n = 0;
		@(posedge clk);
		wr_valid <= 1'b1;
		wr <= {addr, data};
		do begin
			@(posedge clk);
			n++;
		end while (!wr_ready && n < LIMIT);
		if (!wr_ready) begin
			stop_with_failure("write was never accepted");
		end
		wr_valid <= 1'b0;
		if (addr == `SPI_ADDR_CFG) begin
			cfg_model = {data[15:8], data[6:5], data[2], data[3], data[4], data[0]};
		end else if (cfg_model.enable) begin
			cmd = {cfg_model.prescale, cfg_model.select, cfg_model.cpol, cfg_model.cpha,
				cfg_model.lsb_first, data[7:0]};
			sb = 8'($urandom);
			xfer_q.push_back(cmd);
			exp_q.push_back({sb, cfg_model.select, model_seq});
			model_seq++;
			u_slave.load(cfg_model.cpol, cfg_model.cpha, cfg_model.lsb_first, sb);
		end
	endtask

	// mode is {cpol, cpha}
	task automatic configure(input logic en, input logic [1:0] mode, input logic lsb,
			input logic [1:0] sel, input logic [7:0] presc);
		write_reg(`SPI_ADDR_CFG, {16'b0, presc, 1'b0, sel, lsb, mode[0], mode[1], 1'b0, en});
	endtask

	task automatic send_byte();
		write_reg(`SPI_ADDR_DATA, $urandom);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || xfer_q.size() != 0 || active) && n < LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (n >= LIMIT) begin
			stop_with_failure("responses did not arrive in time");
		end
	endtask

	// Select routing, sck spacing, edge count and captured MOSI per transfer
	always @(posedge clk) begin
		if (arst_n) begin
			if (!active && ss_n != '1) begin
				if (xfer_q.size() == 0) begin
					stop_with_failure("slave select went low with no transfer queued");
				end
				cur_xfer = xfer_q.pop_front();
				active = 1'b1;
				gap = 0;
				edges = 0;
				started++;
				compare_ss(select_pattern(cur_xfer.select), ss_n);
			end else if (active && ss_n == '1) begin
				active = 1'b0;
				compare_count(16, edges);
				compare_byte(cur_xfer.tx_data, slave_rx);
			end else if (active) begin
				gap++;
				compare_ss(select_pattern(cur_xfer.select), ss_n);
				if (sck != prev_sck) begin
					compare_count(int'(cur_xfer.prescale) + 1, gap);
					gap = 0;
					edges++;
				end
			end
			prev_sck = sck;
		end
	end

	// Response port against the model
	always @(posedge clk) begin
		spi_rsp_t exp;
		if (arst_n && rsp_valid && rsp_ready) begin
			if (exp_q.size() == 0) begin
				stop_with_failure("response arrived that no transfer produced");
			end
			exp = exp_q.pop_front();
			compare_rsp(exp, rsp);
		end
	end

	initial begin
		int n;
		void'($urandom(32'h4df9));
		arst_n = 1'b0;
		wr_valid = 1'b0;
		wr = '0;
		rsp_ready = 1'b0;
		cfg_model = '0;
		model_seq = '0;
		active = 1'b0;
		started = 0;
		test_name = "reset";
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		compare_ss('1, ss_n);
		compare_bit(1'b0, rsp_valid);
		compare_bit(1'b1, wr_ready);
		compare_bit(1'b1, mosi);
		rsp_ready <= 1'b1;

		// Every polarity, phase and order
		test_name = "modes";
		for (int m = 0; m < 4; m++) begin
			for (int o = 0; o < 2; o++) begin
				configure(1'b1, 2'(m), 1'(o), 2'($urandom_range(3, 0)), 8'($urandom_range(7, 0)));
				repeat (3) send_byte();
				wait_drain();
			end
		end

		test_name = "routing";
		repeat (8) begin
			configure(1'b1, 2'($urandom), 1'($urandom), 2'($urandom), 8'($urandom_range(5, 0)));
			send_byte();
		end
		wait_drain();

		test_name = "disabled";
		configure(1'b0, 2'b00, 1'b0, 2'd1, 8'd0);
		n = started;
		repeat (3) send_byte();
		repeat (50) @(posedge clk);
		compare_count(n, started);

		// Response FIFO fills and then the command FIFO
		test_name = "backpressure";
		rsp_ready <= 1'b0;
		configure(1'b1, 2'($urandom), 1'($urandom), 2'($urandom), 8'd1);
		repeat (2 * `SPI_QUEUE_DEPTH) send_byte();
		n = 0;
		while (wr_ready && n < LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (wr_ready) begin
			stop_with_failure("wr_ready never dropped under back-pressure");
		end
		n = started;
		repeat (100) @(posedge clk);
		compare_count(n, started);
		rsp_ready <= 1'b1;
		wait_drain();
		repeat (5) @(posedge clk);

		if (u_dut.u_props.fail_cnt != 0) begin
			stop_with_failure("assertion checks failed during the run");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// File: verif/spi_tb_slave.sv
`include "spi_macros.svh"

module spi_tb_slave (
	input  logic clk,
	input  logic sck,
	input  logic mosi,
	input  logic [`SPI_SLAVES-1:0] ss_n,
	output logic miso,
	output logic [`SPI_DATA_W-1:0] rx_byte
);
	// Job layout {cpol, cpha, lsb_first, tx byte}
	logic [10:0] job_q[$];
	logic [10:0] job;
	logic active;
	logic prev_sck;
	int edge_n;
	int out_n;
	int in_n;

	task automatic load(input logic cpol, input logic cpha, input logic lsb,
			input logic [7:0] tx);
		job_q.push_back({cpol, cpha, lsb, tx});
	endtask

	// Wire position of the k-th bit in the byte
	function automatic int bit_pos(input int k);
		return job[8] ? k : 7 - k;
	endfunction

	task automatic drive_next();
		miso = job[bit_pos(out_n)];
		out_n++;
	endtask

	initial begin
		miso = 1'b1;
		active = 1'b0;
		rx_byte = '0;
	end

	// Looks at the pins away from the clk edge the DUT works on
	always @(negedge clk) begin
		if (!active && ss_n != '1 && job_q.size() != 0) begin
			job = job_q.pop_front();
			active = 1'b1;
			prev_sck = sck;
			edge_n = 0;
			out_n = 0;
			in_n = 0;
			// cpha 0 needs the first bit before any edge
			if (!job[9]) begin
				drive_next();
			end
		end else if (active && ss_n == '1) begin
			active = 1'b0;
			miso = 1'b1;
		end else if (active && sck != prev_sck) begin
			prev_sck = sck;
			edge_n++;
			// Sample on odd edges for cpha 0, even edges for cpha 1
			if ((edge_n % 2 == 1) != job[9]) begin
				rx_byte[bit_pos(in_n)] = mosi;
				in_n++;
			end else if (out_n < 8) begin
				drive_next();
			end
		end
	end

endmodule

// File: verilog.f
+incdir+include
design/spi_pkg.sv
design/spi_queue.sv
design/spi_cmd_decode.sv
design/spi_shift_engine.sv
design/spi_rsp_collect.sv
design/spi_master_top.sv
verif/spi_tb_slave.sv
verif/spi_props.sv
verif/spi_tb.sv
